// File: hdl/bp_pkg.sv
package bp_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths

    // One 32-bit instruction address
    typedef logic [31:0] addr_t;

    // Eight fetch packets can be in flight
    typedef logic [2:0] fetch_id_t;

    // 2-bit saturating direction counter
    typedef logic [1:0] bp_counter_t;

    // Tag field wide enough for a single-set table, upper bits zero when indexed
    typedef logic [29:0] btb_tag_t;

    // Widest one-hot way vector held in the metadata record
    localparam int MAX_WAYS = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Table entry and per-id metadata

    typedef struct packed {
        logic        valid;
        btb_tag_t    tag;
        logic        is_branch;
        logic        is_call;
        logic        is_return;
        bp_counter_t counter;
    } btb_entry_t;

    typedef struct packed {
        bp_counter_t         counter;
        logic                used;
        logic [MAX_WAYS-1:0] way;
    } bp_meta_t;

    localparam addr_t RESET_PC = 32'h8000_0000;
    localparam int    MAX_IDS  = 8;

    // Counter saturation limits, also the values set on a first sighting
    localparam bp_counter_t CTR_MAX = 2'b11;
    localparam bp_counter_t CTR_MIN = 2'b00;

endpackage

// File: hdl/bp_lookup_if.sv
`timescale 1ns/1ps

interface bp_lookup_if;

    // Request side, from the PC generation stage
    bp_pkg::addr_t     next_pc;
    logic              new_request;
    bp_pkg::addr_t     if_pc;
    bp_pkg::fetch_id_t if_id;
    logic              emit;

    // Response side, valid the cycle after new_request
    logic              hit;
    bp_pkg::addr_t     predicted_pc;
    logic              is_call;
    logic              is_return;

    modport pc_gen (
        output next_pc, new_request, if_pc, if_id, emit,
        input  hit, predicted_pc, is_return
    );

    modport predictor (
        input  next_pc, new_request, if_pc, if_id, emit,
        output hit, predicted_pc, is_call, is_return
    );

endinterface

// File: hdl/bp_update_if.sv
`timescale 1ns/1ps

interface bp_update_if;

    // One resolved control-flow instruction per cycle
    logic              valid;
    bp_pkg::fetch_id_t id;
    bp_pkg::addr_t     pc;
    // Actual next address, pc+4 when not taken
    bp_pkg::addr_t     target;
    logic              taken;
    logic              is_branch;
    logic              is_call;
    logic              is_return;

    modport predictor (
        input valid, id, pc, target, taken, is_branch, is_call, is_return
    );

endinterface

// File: hdl/ras_if.sv
`timescale 1ns/1ps

interface ras_if;

    logic          push;
    logic          pop;
    bp_pkg::addr_t push_addr;
    bp_pkg::addr_t top_addr;

    modport predictor (
        output push, pop, push_addr,
        input  top_addr
    );

    modport stack (
        input  push, pop, push_addr,
        output top_addr
    );

endinterface

// File: hdl/pc_gen.sv
`timescale 1ns/1ps

module pc_gen #(
    parameter int CREDITS = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    bp_lookup_if.pc_gen       lookup,
    output logic              fetch_valid,
    output bp_pkg::addr_t     fetch_pc,
    output bp_pkg::fetch_id_t fetch_id,
    input  logic              credit_return,
    input  logic              redirect,
    input  bp_pkg::addr_t     redirect_pc,
    input  bp_pkg::addr_t     ras_top
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    bp_pkg::addr_t     pc_q;
    bp_pkg::addr_t     next_pc;
    bp_pkg::addr_t     predicted_next;
    bp_pkg::fetch_id_t id_q;
    logic [CNT_W-1:0]  credit_cnt;
    logic              run_q;
    logic              emit;

    ////////////////////////////////////////////////////////////////////////////
    // Next PC selection

    // Low for the first cycle out of reset while RESET_PC is looked up
    assign emit = run_q && (credit_cnt != '0);

    always_comb begin
        if (lookup.hit) begin
            predicted_next = lookup.is_return ? ras_top : lookup.predicted_pc;
        end else begin
            predicted_next = pc_q + 32'd4;
        end
    end

    // Redirect wins over any prediction; without a packet out the PC holds
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (emit) begin
            next_pc = predicted_next;
        end else begin
            next_pc = pc_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fetch PC, id and credit state

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q  <= bp_pkg::RESET_PC;
            run_q <= 1'b0;
            id_q  <= '0;
        end else begin
            pc_q  <= next_pc;
            run_q <= 1'b1;
            if (emit) begin
                id_q <= id_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= CNT_W'(CREDITS);
        end else begin
            case ({credit_return, emit})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Lookup request and fetch packet

    // Tables are read again only when the PC moves
    assign lookup.new_request = emit || redirect || !run_q;
    assign lookup.next_pc     = next_pc;
    assign lookup.if_pc       = pc_q;
    assign lookup.if_id       = id_q;
    assign lookup.emit        = emit;

    assign fetch_valid = emit;
    assign fetch_pc    = pc_q;
    assign fetch_id    = id_q;

endmodule

// File: hdl/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
    parameter int ENTRIES = 16,
    parameter int WAYS    = 2
) (
    input  logic           clk,
    input  logic           rst_n,
    bp_lookup_if.predictor lookup,
    bp_update_if.predictor update,
    ras_if.predictor       ras,
    output logic           fetch_predicted
);

    localparam int IDX_W = $clog2(ENTRIES);
    localparam int TAG_W = 30 - IDX_W;

    typedef logic [IDX_W-1:0] btb_idx_t;

    function automatic btb_idx_t get_index(input bp_pkg::addr_t pc);
        return pc[IDX_W+1:2];
    endfunction

    function automatic bp_pkg::btb_tag_t get_tag(input bp_pkg::addr_t pc);
        bp_pkg::btb_tag_t tag;
        tag = '0;
        tag[TAG_W-1:0] = pc[31 -: TAG_W];
        return tag;
    endfunction

    bp_pkg::btb_entry_t [WAYS-1:0] if_entry;
    bp_pkg::addr_t [WAYS-1:0]      if_target;
    logic [WAYS-1:0]               tag_match;
    logic [WAYS-1:0]               repl_way;
    logic [WAYS-1:0]               upd_way;
    bp_pkg::btb_entry_t            hit_entry;
    bp_pkg::addr_t                 hit_target;
    logic                          hit;
    bp_pkg::bp_meta_t              meta_table [bp_pkg::MAX_IDS];
    bp_pkg::bp_meta_t              meta_wr;
    bp_pkg::bp_meta_t              meta_rd;
    bp_pkg::btb_entry_t            upd_entry;
    logic                          target_write;

    ////////////////////////////////////////////////////////////////////////////
    // Per-way tag and target tables

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        bp_pkg::btb_entry_t tag_table [ENTRIES];
        bp_pkg::addr_t      target_table [ENTRIES];
        bp_pkg::btb_entry_t rd_entry;
        bp_pkg::addr_t      rd_target;

        // Valid bits must start clear, so the tag table is wiped in reset
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                for (int i = 0; i < ENTRIES; i++) begin
                    tag_table[i] <= '0;
                end
            end else if (update.valid && upd_way[w]) begin
                tag_table[get_index(update.pc)] <= upd_entry;
            end
        end

        always_ff @(posedge clk) begin
            if (update.valid && upd_way[w] && target_write) begin
                target_table[get_index(update.pc)] <= update.target;
            end
        end

        // Synchronous read, held until the next request
        always_ff @(posedge clk) begin
            if (lookup.new_request) begin
                rd_entry  <= tag_table[get_index(lookup.next_pc)];
                rd_target <= target_table[get_index(lookup.next_pc)];
            end
        end

        assign if_entry[w]  = rd_entry;
        assign if_target[w] = rd_target;
        assign tag_match[w] = rd_entry.valid && (rd_entry.tag == get_tag(lookup.if_pc));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Hit selection and fetch response

    always_comb begin
        hit_entry  = if_entry[0];
        hit_target = if_target[0];
        for (int w = 0; w < WAYS; w++) begin
            if (tag_match[w]) begin
                hit_entry  = if_entry[w];
                hit_target = if_target[w];
            end
        end
    end

    assign hit                 = |tag_match;
    assign lookup.hit          = hit;
    assign lookup.predicted_pc = hit_target;
    assign lookup.is_call      = hit && hit_entry.is_call;
    assign lookup.is_return    = hit && hit_entry.is_return;
    assign fetch_predicted     = lookup.emit && hit;

    // Return stack follows emitted packets only
    assign ras.push      = lookup.emit && lookup.is_call;
    assign ras.pop       = lookup.emit && lookup.is_return;
    assign ras.push_addr = lookup.if_pc + 32'd4;

    ////////////////////////////////////////////////////////////////////////////
    // Replacement and per-id metadata

    // Rotate on every emitted miss
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            repl_way <= WAYS'(1);
        end else if (lookup.emit && !hit) begin
            repl_way <= (repl_way << 1) | (repl_way >> (WAYS - 1));
        end
    end

    always_comb begin
        meta_wr.counter         = hit_entry.counter;
        meta_wr.used            = hit;
        meta_wr.way             = '0;
        meta_wr.way[WAYS-1:0]   = hit ? tag_match : repl_way;
    end

    always_ff @(posedge clk) begin
        if (lookup.emit) begin
            meta_table[lookup.if_id] <= meta_wr;
        end
    end

    assign meta_rd = meta_table[update.id];
    assign upd_way = meta_rd.way[WAYS-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Resolution update

    always_comb begin
        upd_entry.valid     = 1'b1;
        upd_entry.tag       = get_tag(update.pc);
        upd_entry.is_branch = update.is_branch;
        upd_entry.is_call   = update.is_call;
        upd_entry.is_return = update.is_return;
        if (!meta_rd.used) begin
            // First sighting goes straight to a strong state
            upd_entry.counter = update.taken ? bp_pkg::CTR_MAX : bp_pkg::CTR_MIN;
        end else if (update.taken) begin
            upd_entry.counter = (meta_rd.counter == bp_pkg::CTR_MAX) ?
                                bp_pkg::CTR_MAX : meta_rd.counter + 2'd1;
        end else begin
            upd_entry.counter = (meta_rd.counter == bp_pkg::CTR_MIN) ?
                                bp_pkg::CTR_MIN : meta_rd.counter - 2'd1;
        end
    end

    // Target only moves when the predicted direction flips
    assign target_write = !meta_rd.used || (meta_rd.counter[1] ^ upd_entry.counter[1]);

endmodule

// File: hdl/return_stack.sv
`timescale 1ns/1ps

module return_stack #(
    parameter int RAS_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    ras_if.stack     ras
);

    localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RAS_DEPTH + 1);

    bp_pkg::addr_t    stack_mem [RAS_DEPTH];
    logic [PTR_W-1:0] top_ptr;
    logic [PTR_W-1:0] push_ptr;
    logic [PTR_W-1:0] pop_ptr;
    logic [CNT_W-1:0] depth;

    // Circular neighbours of the top slot
    assign push_ptr = (top_ptr == PTR_W'(RAS_DEPTH - 1)) ? '0 : top_ptr + 1'b1;
    assign pop_ptr  = (top_ptr == '0) ? PTR_W'(RAS_DEPTH - 1) : top_ptr - 1'b1;

    // Full stack wraps over the oldest entry
    always_ff @(posedge clk) begin
        if (ras.push) begin
            stack_mem[push_ptr] <= ras.push_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_ptr <= '0;
            depth   <= '0;
        end else if (ras.push) begin
            top_ptr <= push_ptr;
            if (depth != CNT_W'(RAS_DEPTH)) begin
                depth <= depth + 1'b1;
            end
        end else if (ras.pop && depth != '0) begin
            // Empty pop leaves the pointer on the last entry
            top_ptr <= pop_ptr;
            depth   <= depth - 1'b1;
        end
    end

    assign ras.top_addr = stack_mem[top_ptr];

endmodule

// File: hdl/fetch_bp_top.sv
`timescale 1ns/1ps

module fetch_bp_top #(
    parameter int ENTRIES   = 16,
    parameter int WAYS      = 2,
    parameter int RAS_DEPTH = 4,
    parameter int CREDITS   = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    output logic              fetch_valid,
    output bp_pkg::addr_t     fetch_pc,
    output bp_pkg::fetch_id_t fetch_id,
    output logic              fetch_predicted,
    input  logic              credit_return,
    input  logic              res_valid,
    input  bp_pkg::fetch_id_t res_id,
    input  bp_pkg::addr_t     res_pc,
    input  bp_pkg::addr_t     res_target,
    input  logic              res_taken,
    input  logic              res_is_branch,
    input  logic              res_is_call,
    input  logic              res_is_return,
    input  logic              redirect,
    input  bp_pkg::addr_t     redirect_pc
);

    bp_lookup_if lookup_bus ();
    bp_update_if update_bus ();
    ras_if       ras_bus ();

    // Resolution results from the back end
    assign update_bus.valid     = res_valid;
    assign update_bus.id        = res_id;
    assign update_bus.pc        = res_pc;
    assign update_bus.target    = res_target;
    assign update_bus.taken     = res_taken;
    assign update_bus.is_branch = res_is_branch;
    assign update_bus.is_call   = res_is_call;
    assign update_bus.is_return = res_is_return;

    pc_gen #(
        .CREDITS(CREDITS)
    ) pc_gen_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup       (lookup_bus),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_id     (fetch_id),
        .credit_return(credit_return),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .ras_top      (ras_bus.top_addr)
    );

    branch_predictor #(
        .ENTRIES(ENTRIES),
        .WAYS   (WAYS)
    ) branch_predictor_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup         (lookup_bus),
        .update         (update_bus),
        .ras            (ras_bus),
        .fetch_predicted(fetch_predicted)
    );

    return_stack #(
        .RAS_DEPTH(RAS_DEPTH)
    ) return_stack_i (
        .clk  (clk),
        .rst_n(rst_n),
        .ras  (ras_bus)
    );

endmodule

// File: verif/fetch_bp_chk.sv
`timescale 1ns/1ps

module fetch_bp_chk #(
    parameter int CREDITS = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        fetch_valid,
    input  bp_pkg::addr_t               fetch_pc,
    input  logic [$clog2(CREDITS+1)-1:0] credit_cnt,
    input  logic                        credit_return,
    input  logic                        redirect,
    input  bp_pkg::addr_t               redirect_pc
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] ref_cnt;

    // Own credit count, one down per packet and one up per return
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ref_cnt <= CNT_W'(CREDITS);
        end else if (fetch_valid && !credit_return) begin
            ref_cnt <= ref_cnt - 1'b1;
        end else if (credit_return && !fetch_valid) begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    // Returned credits never push the count past its reset value
    credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        credit_cnt <= CNT_W'(CREDITS)
    ) else $error("credit count rose above the credit limit");

    // Back-pressure
    no_fetch_without_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch_valid |-> (ref_cnt != '0)
    ) else $error("fetch packet sent with no credit left");

    redirect_target: assert property (
        @(posedge clk) disable iff (!rst_n)
        (redirect && (credit_cnt != '0)) |=> (fetch_pc == $past(redirect_pc))
    ) else $error("fetch address after a redirect is not the redirect address");

endmodule

bind pc_gen fetch_bp_chk #(
    .CREDITS(CREDITS)
) chk_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .credit_cnt   (credit_cnt),
    .credit_return(credit_return),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc)
);

// File: verif/fetch_bp_tb.sv
`timescale 1ns/1ps

module fetch_bp_tb;

    localparam int            CREDITS        = 4;
    localparam int            RAS_DEPTH      = 4;
    localparam int            TIMEOUT_CYCLES = 4000;
    localparam bp_pkg::addr_t P_PC           = 32'h0000_2010;
    localparam bp_pkg::addr_t T_PC           = 32'h0000_3020;
    localparam bp_pkg::addr_t C_PC           = 32'h0000_4030;
    localparam bp_pkg::addr_t F_PC           = 32'h0000_5044;
    localparam bp_pkg::addr_t R_PC           = 32'h0000_504c;

    logic              clk;
    logic              rst_n;
    logic              fetch_valid;
    bp_pkg::addr_t     fetch_pc;
    bp_pkg::fetch_id_t fetch_id;
    logic              fetch_predicted;
    logic              credit_return;
    logic              res_valid;
    bp_pkg::fetch_id_t res_id;
    bp_pkg::addr_t     res_pc;
    bp_pkg::addr_t     res_target;
    logic              res_taken;
    logic              res_is_branch;
    logic              res_is_call;
    logic              res_is_return;
    logic              redirect;
    bp_pkg::addr_t     redirect_pc;

    // Reference model of the expected fetch stream
    string               test_name = "reset";
    int                  credits = CREDITS;
    int                  emitted = 0;
    int                  cycle_cnt = 0;
    logic                credits_on = 1'b0;
    bp_pkg::addr_t       exp_pc = bp_pkg::RESET_PC;
    bp_pkg::fetch_id_t   exp_id = '0;
    bp_pkg::addr_t       last_pc;
    bp_pkg::fetch_id_t   last_id;
    logic                last_predicted;
    bp_pkg::fetch_id_t   p_id = '0;
    bp_pkg::addr_t       m_tgt [bp_pkg::addr_t];
    bp_pkg::bp_counter_t m_ctr [bp_pkg::addr_t];
    logic                m_call [bp_pkg::addr_t];
    logic                m_ret [bp_pkg::addr_t];
    logic                used_m [bp_pkg::MAX_IDS];
    bp_pkg::bp_counter_t ctr_m [bp_pkg::MAX_IDS];
    bp_pkg::addr_t       ras_q [$];
    bp_pkg::addr_t       ras_last = '0;

    // Requests for the next cycle
    logic                redir_pend = 1'b0;
    bp_pkg::addr_t       redir_addr = '0;
    logic                res_pend = 1'b0;
    bp_pkg::addr_t       r_pc = '0;
    bp_pkg::addr_t       r_tgt = '0;
    logic                r_taken = 1'b0;
    logic                r_call = 1'b0;
    logic                r_ret = 1'b0;
    bp_pkg::addr_t       rand_addr;

    fetch_bp_top #(
        .ENTRIES  (16),
        .WAYS     (2),
        .RAS_DEPTH(RAS_DEPTH),
        .CREDITS  (CREDITS)
    ) fetch_bp_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_id       (fetch_id),
        .fetch_predicted(fetch_predicted),
        .credit_return  (credit_return),
        .res_valid      (res_valid),
        .res_id         (res_id),
        .res_pc         (res_pc),
        .res_target     (res_target),
        .res_taken      (res_taken),
        .res_is_branch  (res_is_branch),
        .res_is_call    (res_is_call),
        .res_is_return  (res_is_return),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Far above the cycle count of the whole sequence
    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

    task automatic report_mismatch(input string field, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR %s %s expected %0h actual %0h", test_name, field, expected, actual);
        $display("*** FAILED ***");
        $fatal(1, "%s mismatch", field);
    endtask

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else report_mismatch(field, expected, actual);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Check outputs, drive inputs and advance the model once per cycle

    task automatic tick();
        logic                hit;
        bp_pkg::addr_t       next;
        bp_pkg::bp_counter_t old_ctr;
        bp_pkg::bp_counter_t new_ctr;
        @(negedge clk);
        assert (fetch_valid == (credits > 0))
            else report_mismatch("fetch_valid", 32'(credits > 0), 32'(fetch_valid));
        credit_return = credits_on && (credits < CREDITS) && ($urandom_range(0, 1) == 32'd1);
        redirect      = redir_pend;
        redirect_pc   = redir_addr;
        res_valid     = res_pend;
        res_id        = p_id;
        res_pc        = r_pc;
        res_target    = r_tgt;
        res_taken     = r_taken;
        res_is_branch = !(r_call || r_ret);
        res_is_call   = r_call;
        res_is_return = r_ret;
        redir_pend    = 1'b0;
        res_pend      = 1'b0;
        if (fetch_valid) begin
            hit = (m_tgt.exists(exp_pc) != 0);
            check_value("fetch_pc", exp_pc, fetch_pc);
            check_value("fetch_id", 32'(exp_id), 32'(fetch_id));
            check_value("fetch_predicted", 32'(hit), 32'(fetch_predicted));
            used_m[fetch_id] = hit;
            ctr_m[fetch_id]  = 2'b00;
            next = exp_pc + 32'd4;
            if (hit) begin
                ctr_m[fetch_id] = m_ctr[exp_pc];
                if (m_ret[exp_pc]) begin
                    if (ras_q.size() != 0) ras_last = ras_q.pop_back();
                    next = ras_last;
                end else begin
                    next = m_tgt[exp_pc];
                    if (m_call[exp_pc]) ras_q.push_back(exp_pc + 32'd4);
                    // Oldest return address falls off a full stack
                    if (ras_q.size() > RAS_DEPTH) ras_q.delete(0);
                end
            end
            last_pc        = fetch_pc;
            last_id        = fetch_id;
            last_predicted = fetch_predicted;
            exp_pc         = next;
            exp_id         = exp_id + 3'd1;
            emitted++;
            credits--;
        end
        if (credit_return) credits++;
        if (redirect) exp_pc = redirect_pc;
        if (res_valid) begin
            old_ctr = ctr_m[res_id];
            if (!used_m[res_id]) begin
                new_ctr = res_taken ? 2'b11 : 2'b00;
            end else if (res_taken) begin
                new_ctr = (old_ctr == 2'b11) ? old_ctr : old_ctr + 2'b01;
            end else begin
                new_ctr = (old_ctr == 2'b00) ? old_ctr : old_ctr - 2'b01;
            end
            if (!used_m[res_id] || (new_ctr[1] != old_ctr[1])) m_tgt[res_pc] = res_target;
            m_ctr[res_pc]  = new_ctr;
            m_call[res_pc] = res_is_call;
            m_ret[res_pc]  = res_is_return;
        end
    endtask

    task automatic run_packets(input int n);
        int goal;
        goal = emitted + n;
        while (emitted < goal) tick();
    endtask

    // Redirect, then fetch n packets; p_id is the id of the first one
    task automatic go(input bp_pkg::addr_t addr, input int n);
        redir_pend = 1'b1;
        redir_addr = addr;
        credits_on = 1'b1;
        tick();
        run_packets(1);
        p_id = last_id;
        run_packets(n - 1);
    endtask

    task automatic stall();
        credits_on = 1'b0;
        while (credits != 0) tick();
    endtask

    task automatic resolve(input bp_pkg::addr_t pc, input bp_pkg::addr_t tgt,
                           input logic taken, input logic call, input logic ret);
        res_pend = 1'b1;
        r_pc     = pc;
        r_tgt    = tgt;
        r_taken  = taken;
        r_call   = call;
        r_ret    = ret;
        tick();
    endtask

    task automatic train(input bp_pkg::addr_t pc, input bp_pkg::addr_t tgt,
                         input logic taken, input logic call, input logic ret);
        go(pc, 1);
        stall();
        resolve(pc, tgt, taken, call, ret);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        rst_n         = 1'b0;
        credit_return = 1'b0;
        res_valid     = 1'b0;
        res_id        = '0;
        res_pc        = '0;
        res_target    = '0;
        res_taken     = 1'b0;
        res_is_branch = 1'b0;
        res_is_call   = 1'b0;
        res_is_return = 1'b0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        void'($urandom(32'h9d20_ef57));
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        test_name = "sequential";
        run_packets(CREDITS);
        repeat (8) tick();
        check_value("packets", CREDITS, emitted);
        check_value("last_pc", bp_pkg::RESET_PC + 32'd12, last_pc);

        test_name  = "credits";
        credits_on = 1'b1;
        run_packets(24);
        check_value("last_id", (CREDITS + 23) % bp_pkg::MAX_IDS, 32'(last_id));

        test_name = "redirect";
        rand_addr = $urandom() & 32'h0fff_fffc;
        go(rand_addr, 6);
        check_value("last_pc", rand_addr + 32'd20, last_pc);

        test_name = "taken_branch";
        train(P_PC, T_PC, 1'b1, 1'b0, 1'b0);
        go(P_PC - 32'd8, 3);
        check_value("predicted", 32'd1, 32'(last_predicted));
        run_packets(1);
        check_value("target", T_PC, last_pc);

        // Counter 11 to 10 keeps the target, 10 to 01 rewrites it
        test_name = "hysteresis";
        go(P_PC, 1);
        stall();
        resolve(P_PC, P_PC + 32'd4, 1'b0, 1'b0, 1'b0);
        go(P_PC, 2);
        check_value("weak_target", T_PC, last_pc);
        stall();
        resolve(P_PC, P_PC + 32'd4, 1'b0, 1'b0, 1'b0);
        go(P_PC, 2);
        check_value("flipped_target", P_PC + 32'd4, last_pc);

        // Return trained with a stored target unlike the stacked address
        test_name = "call_return";
        train(C_PC, F_PC, 1'b1, 1'b1, 1'b0);
        train(R_PC, T_PC, 1'b1, 1'b0, 1'b1);
        go(C_PC, 2);
        check_value("call_target", F_PC, last_pc);
        run_packets(2);
        check_value("return_hit", 32'd1, 32'(last_predicted));
        run_packets(1);
        check_value("return_addr", C_PC + 32'd4, last_pc);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: fetch_bp.f
hdl/bp_pkg.sv
hdl/bp_lookup_if.sv
hdl/bp_update_if.sv
hdl/ras_if.sv
hdl/pc_gen.sv
hdl/branch_predictor.sv
hdl/return_stack.sv
hdl/fetch_bp_top.sv
verif/fetch_bp_chk.sv
verif/fetch_bp_tb.sv

// File: Makefile
# Verilator simulation of the fetch front end

OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f fetch_bp.f \
		--top-module fetch_bp_tb -Mdir $(OBJ_DIR) -o fetch_bp_sim

run: compile
	./$(OBJ_DIR)/fetch_bp_sim

clean:
	rm -rf $(OBJ_DIR)
